// ==== all.f ====
+incdir+rtl
rtl/fcvt_pkg.sv
rtl/fcvt_apb_regs.sv
rtl/fcvt_unpack.sv
rtl/fcvt_round_shift.sv
rtl/fcvt_result_fifo.sv
rtl/fcvt_top.sv
sim/fcvt_sva.sv
sim/fcvt_tb.sv

// ==== rtl/fcvt_apb_regs.sv ====
// APB register block of the FP-to-integer converter
// Holds CTRL and SRC, launches conversions on ISSUE, reads back the result queue
`timescale 1ns/1ps
`include "fcvt_defs.svh"

module fcvt_apb_regs import fcvt_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [4:0]  paddr,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  output cvt_req_t    req,
  input  cvt_res_t    head,
  input  q_count_t    count,
  output logic        pop
);

  logic        access;
  logic        setup_rd;
  logic        wr_acc;
  logic        rd_acc;
  logic        res_addr;
  logic        issue_wr;
  logic        issue_refused;
  logic        issue_ok;
  logic        empty_rd;
  logic        q_nonempty;
  logic        rd_empty_q;  // Queue state sampled in the setup phase
  cvt_op_t     ctrl_op;
  rmode_t      ctrl_rm;
  logic [31:0] src_lo;
  logic [31:0] src_hi;
  q_count_t    credits;     // Queued plus in-flight conversions
  logic [31:0] rd_mux;
  logic        req_vld;
  cvt_op_t     req_op;
  rmode_t      req_rm;
  fp_word_t    req_src;

  assign pready     = 1'b1;  // Zero wait states
  assign access     = psel & penable;
  assign setup_rd   = psel & ~penable & ~pwrite;
  assign wr_acc     = access & pwrite;
  assign rd_acc     = access & ~pwrite;
  assign q_nonempty = (count != '0);
  assign res_addr   = (paddr == `FCVT_ADDR_RES_LO) || (paddr == `FCVT_ADDR_RES_HI);

  assign issue_wr      = wr_acc && (paddr == `FCVT_ADDR_ISSUE);
  assign issue_refused = issue_wr && (credits == q_count_t'(`FCVT_QDEPTH));
  assign issue_ok      = issue_wr && !issue_refused;
  assign empty_rd      = rd_acc && res_addr && rd_empty_q;
  assign pop           = rd_acc && (paddr == `FCVT_ADDR_RES_HI) && !rd_empty_q;
  assign pslverr       = issue_refused | empty_rd;

  always_comb begin
    case (paddr)
      `FCVT_ADDR_CTRL:   rd_mux = {28'd0, ctrl_rm, ctrl_op};
      `FCVT_ADDR_SRC_LO: rd_mux = src_lo;
      `FCVT_ADDR_SRC_HI: rd_mux = src_hi;
      `FCVT_ADDR_RES_LO: rd_mux = q_nonempty ? head.value[31:0] : 32'd0;
      `FCVT_ADDR_RES_HI: rd_mux = q_nonempty ? head.value[63:32] : 32'd0;
      `FCVT_ADDR_STATUS: rd_mux = {26'd0, q_nonempty & head.inexact,
                                   q_nonempty & head.invalid, 1'b0, count};
      default:           rd_mux = 32'd0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_op    <= '0;
      ctrl_rm    <= '0;
      src_lo     <= '0;
      src_hi     <= '0;
      prdata     <= '0;
      rd_empty_q <= 1'b1;
      credits    <= '0;
      req_vld    <= 1'b0;
    end else begin
      if (wr_acc && paddr == `FCVT_ADDR_CTRL) begin
        ctrl_op <= pwdata[1:0];
        ctrl_rm <= pwdata[3:2];
      end
      if (wr_acc && paddr == `FCVT_ADDR_SRC_LO) src_lo <= pwdata;
      if (wr_acc && paddr == `FCVT_ADDR_SRC_HI) src_hi <= pwdata;
      if (setup_rd) begin
        prdata     <= rd_mux;     // Data is ready for the access phase
        rd_empty_q <= !q_nonempty;
      end
      credits <= credits + q_count_t'(issue_ok) - q_count_t'(pop);
      req_vld <= issue_ok;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_ok) begin
      req_op  <= ctrl_op;
      req_rm  <= ctrl_rm;
      req_src <= {src_hi, src_lo};
    end
  end

  assign req = '{valid: req_vld, op: req_op, rmode: req_rm, operand: req_src};

endmodule

// ==== rtl/fcvt_defs.svh ====
// FP-to-integer converter constants
// Register map, queue depth, rounding and operation codes, integer limits
`ifndef FCVT_DEFS_SVH
`define FCVT_DEFS_SVH

`define FCVT_QDEPTH 4

`define FCVT_ADDR_CTRL   5'h00
`define FCVT_ADDR_SRC_LO 5'h04
`define FCVT_ADDR_SRC_HI 5'h08
`define FCVT_ADDR_ISSUE  5'h0C
`define FCVT_ADDR_RES_LO 5'h10
`define FCVT_ADDR_RES_HI 5'h14
`define FCVT_ADDR_STATUS 5'h18

`define FCVT_RM_RNE 2'd0
`define FCVT_RM_RTZ 2'd1
`define FCVT_RM_RDN 2'd2
`define FCVT_RM_RUP 2'd3

`define FCVT_OP_SRC_SNG 0  // Source is single precision
`define FCVT_OP_DST_32  1  // Destination is int32

`define FCVT_I64_MAX 64'h7FFF_FFFF_FFFF_FFFF
`define FCVT_I64_MIN 64'h8000_0000_0000_0000
`define FCVT_I32_MAX 64'h0000_0000_7FFF_FFFF
`define FCVT_I32_MIN 64'hFFFF_FFFF_8000_0000

`endif

// ==== rtl/fcvt_pkg.sv ====
// FP-to-integer converter types
// Word typedefs and the packed records passed between pipeline stages
package fcvt_pkg;

  typedef logic [63:0]        fp_word_t;   // Single precision sits in bits 31:0
  typedef logic [63:0]        int_word_t;  // 32-bit results are sign-extended
  typedef logic [1:0]         rmode_t;
  typedef logic [1:0]         cvt_op_t;
  typedef logic [2:0]         q_count_t;   // Queue fill level 0..4
  typedef logic signed [12:0] exp_t;       // Unbiased exponent
  typedef logic [52:0]        mant_t;      // Mantissa with hidden bit at 52

  typedef struct packed {
    logic     valid;
    cvt_op_t  op;
    rmode_t   rmode;
    fp_word_t operand;
  } cvt_req_t;

  typedef struct packed {
    logic    valid;
    cvt_op_t op;
    rmode_t  rmode;
    logic    sign;
    logic    is_nan;
    logic    is_inf;
    logic    is_zero;
    exp_t    exp;
    mant_t   mant;
  } cvt_unp_t;

  typedef struct packed {
    logic      valid;
    int_word_t value;
    logic      invalid;
    logic      inexact;
  } cvt_res_t;

endpackage

// ==== rtl/fcvt_result_fifo.sv ====
// Result queue of the FP-to-integer converter
// Circular buffer with a fill count and a head view of the oldest entry
`timescale 1ns/1ps
`include "fcvt_defs.svh"

module fcvt_result_fifo import fcvt_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  cvt_res_t push,
  input  logic     pop,
  output cvt_res_t head,
  output q_count_t count
);

  localparam int DEPTH = `FCVT_QDEPTH;
  localparam int PW    = $clog2(DEPTH);

  cvt_res_t      mem [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;

  function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] p);
    ptr_next = (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // Credits upstream keep pushes off a full queue
  always_ff @(posedge clk) begin
    if (push.valid) mem[wr_ptr] <= push;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push.valid) wr_ptr <= ptr_next(wr_ptr);
      if (pop)        rd_ptr <= ptr_next(rd_ptr);
      count <= count + q_count_t'(push.valid) - q_count_t'(pop);
    end
  end

  assign head = mem[rd_ptr];  // Oldest entry, no read latency

endmodule

// ==== rtl/fcvt_round_shift.sv ====
// Align, round and saturate stages of the FP-to-integer converter
// Stage 2 registers the aligned magnitude, stage 3 rounds and range-checks it
`timescale 1ns/1ps
`include "fcvt_defs.svh"

module fcvt_round_shift import fcvt_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  cvt_unp_t unp,
  output cvt_res_t res
);

  exp_t         ex;
  exp_t         sh_amt;
  logic [116:0] wide;      // Mantissa over 64 integer and 53 fraction bits
  logic [63:0]  mag_d;
  logic         guard_d;
  logic         sticky_d;
  logic         big_d;

  logic         s2_vld;
  cvt_op_t      s2_op;
  rmode_t       s2_rm;
  logic         s2_sign;
  logic         s2_nan;
  logic         s2_big;
  logic [63:0]  s2_mag;
  logic         s2_guard;
  logic         s2_sticky;

  logic         lost;
  logic         inc;
  logic         dst32;
  logic [64:0]  mag_r;
  int_word_t    max_v;
  int_word_t    min_v;
  logic [63:0]  lim;       // Largest magnitude allowed for this sign
  logic         ovf;
  int_word_t    sval;

  assign ex     = unp.exp;
  assign sh_amt = 13'sd63 - ex;
  assign wide   = {unp.mant, 64'd0} >> sh_amt[6:0];

  always_comb begin
    big_d = unp.is_inf | unp.is_nan | (ex >= 13'sd64);  // Magnitude at least 2^64
    if (ex < -13'sd1) begin
      mag_d    = '0;
      guard_d  = 1'b0;
      sticky_d = ~unp.is_zero;  // Below one half
    end else begin
      mag_d    = wide[116:53];
      guard_d  = wide[52];
      sticky_d = |wide[51:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) s2_vld <= 1'b0;
    else        s2_vld <= unp.valid;
  end

  always_ff @(posedge clk) begin
    if (unp.valid) begin
      s2_op     <= unp.op;
      s2_rm     <= unp.rmode;
      s2_sign   <= unp.sign;
      s2_nan    <= unp.is_nan;
      s2_big    <= big_d;
      s2_mag    <= mag_d;
      s2_guard  <= guard_d;
      s2_sticky <= sticky_d;
    end
  end

  assign lost = s2_guard | s2_sticky;

  always_comb begin
    case (s2_rm)
      `FCVT_RM_RNE: inc = s2_guard & (s2_sticky | s2_mag[0]);  // Ties to even
      `FCVT_RM_RDN: inc = s2_sign & lost;
      `FCVT_RM_RUP: inc = ~s2_sign & lost;
      default:      inc = 1'b0;  // Toward zero truncates
    endcase
  end

  assign mag_r = {1'b0, s2_mag} + 65'(inc);
  assign dst32 = s2_op[`FCVT_OP_DST_32];
  assign max_v = dst32 ? `FCVT_I32_MAX : `FCVT_I64_MAX;
  assign min_v = dst32 ? `FCVT_I32_MIN : `FCVT_I64_MIN;
  assign lim   = s2_sign ? (64'd0 - min_v) : max_v;
  assign ovf   = s2_big | (mag_r > {1'b0, lim});
  assign sval  = s2_sign ? (64'd0 - mag_r[63:0]) : mag_r[63:0];

  always_comb begin
    res.valid   = s2_vld;
    res.invalid = 1'b0;
    res.inexact = 1'b0;
    if (s2_nan) begin
      res.value   = max_v;
      res.invalid = 1'b1;
    end else if (ovf) begin
      res.value   = s2_sign ? min_v : max_v;  // Saturate by sign
      res.invalid = 1'b1;
    end else begin
      res.value   = sval;  // 64-bit negate already sign-extends int32 results
      res.inexact = lost;
    end
  end

endmodule

// ==== rtl/fcvt_top.sv ====
// FP-to-integer conversion unit with an APB register interface
// Register block, unpack stage, round/shift stages and result queue
`timescale 1ns/1ps

module fcvt_top import fcvt_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [4:0]  paddr,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);

  cvt_req_t req;
  cvt_unp_t unp;
  cvt_res_t res;
  cvt_res_t head;
  q_count_t count;
  logic     pop;

  fcvt_apb_regs u_regs (
    .clk, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata,
    .prdata, .pready, .pslverr, .req, .head, .count, .pop
  );

  fcvt_unpack u_unpack (.clk, .rst_n, .req, .unp);

  fcvt_round_shift u_round (.clk, .rst_n, .unp, .res);

  fcvt_result_fifo u_fifo (
    .clk, .rst_n, .push(res), .pop, .head, .count
  );

endmodule

// ==== rtl/fcvt_unpack.sv ====
// Unpack stage of the FP-to-integer converter
// Splits the operand into sign, unbiased exponent and mantissa, and classifies it
`timescale 1ns/1ps
`include "fcvt_defs.svh"

module fcvt_unpack import fcvt_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  cvt_req_t req,
  output cvt_unp_t unp
);

  logic        sng;
  logic [10:0] e_fld;
  logic [51:0] f_fld;  // Fraction left-aligned to the double layout
  logic        e_max;
  logic        e_zero;
  logic        f_zero;
  exp_t        bias;
  cvt_unp_t    nxt;
  cvt_unp_t    pl_q;
  logic        vld_q;

  assign sng = req.op[`FCVT_OP_SRC_SNG];

  always_comb begin
    if (sng) begin
      e_fld = {3'd0, req.operand[30:23]};
      f_fld = {req.operand[22:0], 29'd0};
      e_max = &req.operand[30:23];
      bias  = 13'sd127;
    end else begin
      e_fld = req.operand[62:52];
      f_fld = req.operand[51:0];
      e_max = &req.operand[62:52];
      bias  = 13'sd1023;
    end
  end

  assign e_zero = (e_fld == '0);
  assign f_zero = (f_fld == '0);

  always_comb begin
    nxt         = '0;
    nxt.valid   = 1'b1;
    nxt.op      = req.op;
    nxt.rmode   = req.rmode;
    nxt.sign    = sng ? req.operand[31] : req.operand[63];
    nxt.is_nan  = e_max & ~f_zero;
    nxt.is_inf  = e_max & f_zero;
    nxt.is_zero = e_zero & f_zero;
    // Subnormals take the minimum exponent and no hidden bit
    nxt.exp     = e_zero ? (exp_t'(1) - bias) : (exp_t'({2'b00, e_fld}) - bias);
    nxt.mant    = {~e_zero, f_fld};
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) vld_q <= 1'b0;
    else        vld_q <= req.valid;
  end

  always_ff @(posedge clk) begin
    if (req.valid) pl_q <= nxt;
  end

  always_comb begin
    unp       = pl_q;
    unp.valid = vld_q;
  end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the FP-to-integer converter testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module fcvt_tb -f all.f -o fcvt_sim
./obj_dir/fcvt_sim 2>&1 | tee sim.log

if grep -q "^PASS: all tests$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// ==== sim/fcvt_sva.sv ====
// Assertions for the FP-to-integer converter
// APB response rules and result queue occupancy, bound into the top level
`timescale 1ns/1ps
`include "fcvt_defs.svh"

module fcvt_sva import fcvt_pkg::*; (
  input logic     clk,
  input logic     rst_n,
  input logic     psel,
  input logic     penable,
  input logic     pready,
  input logic     pslverr,
  input q_count_t count,
  input logic     push_vld,
  input logic     pop
);

  a_pready_high: assert property (@(posedge clk) disable iff (!rst_n) pready)
    else $error("pready went low");

  a_count_range: assert property (@(posedge clk) disable iff (!rst_n)
    count <= q_count_t'(`FCVT_QDEPTH))
    else $error("queue count above depth");

  // Credits must keep the pipeline from pushing into a full queue
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    (count == q_count_t'(`FCVT_QDEPTH) && !pop) |-> !push_vld)
    else $error("push into a full queue");

  a_slverr_access: assert property (@(posedge clk) disable iff (!rst_n)
    pslverr |-> (psel && penable))
    else $error("pslverr outside an access cycle");

endmodule

bind fcvt_top fcvt_sva u_sva (
  .clk, .rst_n, .psel, .penable, .pready, .pslverr, .count,
  .push_vld(res.valid), .pop
);

// ==== sim/fcvt_tb.sv ====
// Testbench for the FP-to-integer converter
// Issues conversions over APB and checks each result against a reference model
`timescale 1ns/1ps
`include "fcvt_defs.svh"

module fcvt_tb;

  typedef struct packed {
    logic [63:0] value;
    logic        invalid;
    logic        inexact;
  } result_t;

  localparam int N_DIR   = 32;
  localparam int N_RAND  = 300;
  localparam int N_XFER  = (N_DIR * 16 + N_RAND + 8) * 12;  // About 12 transfers per conversion
  localparam int XFER_NS = 20;                              // Upper bound for one transfer

  // Single encodings first, then doubles, each run through every op and mode
  localparam logic [63:0] DIR_VALS [N_DIR] = '{
    64'h3F00_0000, 64'h3FC0_0000, 64'h4020_0000, 64'hBFC0_0000,
    64'hBF00_0000, 64'h0000_0000, 64'h8000_0001, 64'h0000_0001,
    64'h4EFF_FFFF, 64'hCF00_0000, 64'h5EFF_FFFF, 64'hDF00_0000,
    64'h7FC0_0000, 64'h7F80_0000, 64'hFF80_0000, 64'h5F00_0000,
    64'h3FE0_0000_0000_0000, 64'h3FF8_0000_0000_0000, 64'h4004_0000_0000_0000,
    64'hBFF8_0000_0000_0000, 64'hBFE0_0000_0000_0000, 64'h8000_0000_0000_0000,
    64'h0000_0000_0000_0001, 64'h41DF_FFFF_FFC0_0000, 64'h41DF_FFFF_FFE0_0000,
    64'hC1E0_0000_0000_0000, 64'h43DF_FFFF_FFFF_FFFF, 64'hC3E0_0000_0000_0000,
    64'h7FF8_0000_0000_0000, 64'hFFF0_0000_0000_0000, 64'h7FF0_0000_0000_0000,
    64'h43E0_0000_0000_0000
  };

  logic        clk;
  logic        rst_n;
  logic [4:0]  paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  logic [63:0] rng;
  int          err_cnt;
  int          n_issued;
  int          n_checked;
  result_t     exp_q [$];
  result_t     obs_q [$];
  event        got_result;

  fcvt_top u_dut (.*);

  always #2 clk = ~clk;

  function automatic logic [63:0] xorshift();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 7);
    rng = rng ^ (rng << 17);
    return rng;
  endfunction

  // Exact value is m * 2^e2, split into integer part and discarded fraction
  function automatic result_t ref_convert(input logic [1:0] op, input logic [1:0] rm,
                                          input logic [63:0] src);
    logic         sign;
    logic         special;
    logic         frac_nz;
    logic         dst32;
    logic [52:0]  m;
    int           e2;
    logic [127:0] ip;
    logic [127:0] rem;
    logic [127:0] half;
    logic [127:0] lim;
    logic         up;
    result_t      r;
    r     = '0;
    dst32 = op[`FCVT_OP_DST_32];
    if (op[`FCVT_OP_SRC_SNG]) begin
      sign    = src[31];
      special = &src[30:23];
      frac_nz = |src[22:0];
      m       = {29'd0, src[30:23] != 8'd0, src[22:0]};
      e2      = (src[30:23] == 8'd0) ? -149 : int'(src[30:23]) - 150;
    end else begin
      sign    = src[63];
      special = &src[62:52];
      frac_nz = |src[51:0];
      m       = {src[62:52] != 11'd0, src[51:0]};
      e2      = (src[62:52] == 11'd0) ? -1074 : int'(src[62:52]) - 1075;
    end
    if (special && frac_nz) begin
      r.value   = dst32 ? `FCVT_I32_MAX : `FCVT_I64_MAX;
      r.invalid = 1'b1;
      return r;
    end
    lim  = dst32 ? (128'd1 << 31) : (128'd1 << 63);
    lim  = sign ? lim : lim - 128'd1;  // Negative side reaches one further
    ip   = '0;
    rem  = '0;
    half = '0;
    if (special) ip = '1;                      // Infinity is beyond every range
    else if (e2 > 70) ip = '1;
    else if (e2 >= 0) ip = 128'(m) << e2;
    else if (e2 < -60) begin
      rem  = 128'(m);
      half = 128'd1 << 60;                     // m is always far below one half here
    end else begin
      ip   = 128'(m) >> (-e2);
      rem  = 128'(m) & ((128'd1 << (-e2)) - 128'd1);
      half = 128'd1 << (-e2 - 1);
    end
    case (rm)
      `FCVT_RM_RNE: up = (rem > half) || (rem == half && rem != 0 && ip[0]);
      `FCVT_RM_RTZ: up = 1'b0;
      `FCVT_RM_RDN: up = sign && rem != 0;
      default:      up = !sign && rem != 0;
    endcase
    ip = ip + 128'(up);
    if (ip > lim) begin
      r.value   = sign ? (dst32 ? `FCVT_I32_MIN : `FCVT_I64_MIN)
                       : (dst32 ? `FCVT_I32_MAX : `FCVT_I64_MAX);
      r.invalid = 1'b1;
    end else begin
      r.value   = sign ? (64'd0 - ip[63:0]) : ip[63:0];
      r.inexact = (rem != 0);
    end
    return r;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("error: %s got %h expected %h", name, got, exp);
      $display("FAIL: see errors above");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic write_reg(input logic [4:0] addr, input logic [31:0] data, output logic err);
    @(negedge clk);
    paddr   = addr;
    pwdata  = data;
    pwrite  = 1'b1;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    #1 err  = pslverr;
    check_value("pready", 64'(pready), 64'd1);
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic read_reg(input logic [4:0] addr, output logic [31:0] data, output logic err);
    @(negedge clk);
    paddr   = addr;
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    #1;
    data    = prdata;
    err     = pslverr;
    check_value("pready", 64'(pready), 64'd1);
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic issue_conv(input logic [1:0] op, input logic [1:0] rm, input logic [63:0] src);
    logic err;
    write_reg(`FCVT_ADDR_CTRL, {28'd0, rm, op}, err);
    write_reg(`FCVT_ADDR_SRC_LO, src[31:0], err);
    write_reg(`FCVT_ADDR_SRC_HI, src[63:32], err);
    write_reg(`FCVT_ADDR_ISSUE, 32'd1, err);
    check_value("pslverr on issue", 64'(err), 64'd0);
    exp_q.push_back(ref_convert(op, rm, src));
    n_issued++;
  endtask

  // Waits for a queued result, reads flags from STATUS, then pops via RES_HI
  task automatic collect_result();
    logic [31:0] st;
    logic [31:0] lo;
    logic [31:0] hi;
    logic        err;
    int          polls;
    polls = 0;
    st    = '0;
    while (st[2:0] == 3'd0 && polls < 20) begin
      read_reg(`FCVT_ADDR_STATUS, st, err);
      polls++;
    end
    if (st[2:0] == 3'd0) begin
      $display("no result reached the queue after %0d status polls", polls);
      $display("FAIL: see errors above");
      $fatal(1, "result never arrived");
    end
    read_reg(`FCVT_ADDR_RES_LO, lo, err);
    check_value("pslverr on RES_LO", 64'(err), 64'd0);
    read_reg(`FCVT_ADDR_RES_HI, hi, err);
    check_value("pslverr on RES_HI", 64'(err), 64'd0);
    obs_q.push_back('{value: {hi, lo}, invalid: st[4], inexact: st[5]});
    -> got_result;
  endtask

  initial begin
    result_t e;
    result_t o;
    forever begin
      @(got_result);
      while (obs_q.size() != 0) begin
        o = obs_q.pop_front();
        e = exp_q.pop_front();
        check_value("result value", o.value, e.value);
        check_value("invalid flag", 64'(o.invalid), 64'(e.invalid));
        check_value("inexact flag", 64'(o.inexact), 64'(e.inexact));
        n_checked++;
      end
    end
  end

  initial begin
    #(N_XFER * XFER_NS);
    $display("timeout: the run did not finish within %0d ns", N_XFER * XFER_NS);
    $display("FAIL: see errors above");
    $fatal(1, "watchdog expired");
  end

  initial begin
    logic [31:0] st;
    logic [31:0] d;
    logic        err;
    logic [63:0] r;
    logic [63:0] src;
    int          polls;
    clk       = 1'b0;
    rst_n     = 1'b0;
    paddr     = '0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    pwdata    = '0;
    rng       = 64'd91;
    err_cnt   = 0;
    n_issued  = 0;
    n_checked = 0;
    repeat (2) @(posedge clk);
    @(negedge clk) rst_n = 1'b1;

    read_reg(`FCVT_ADDR_STATUS, st, err);
    check_value("STATUS after reset", 64'(st), 64'd0);
    read_reg(`FCVT_ADDR_RES_LO, d, err);
    check_value("pslverr on empty RES_LO", 64'(err), 64'd1);
    check_value("prdata on empty RES_LO", 64'(d), 64'd0);
    read_reg(`FCVT_ADDR_RES_HI, d, err);
    check_value("pslverr on empty RES_HI", 64'(err), 64'd1);
    check_value("prdata on empty RES_HI", 64'(d), 64'd0);

    for (int i = 0; i < N_DIR; i++) begin
      for (int op = 0; op < 4; op++) begin
        for (int rm = 0; rm < 4; rm++) begin
          issue_conv(2'(op), 2'(rm), DIR_VALS[i]);
          collect_result();
        end
      end
    end

    for (int n = 0; n < N_RAND; n++) begin
      r   = xorshift();
      src = xorshift();
      if (r[5:4] != 2'd0) begin  // Mostly exponents around the integer range
        if (r[0]) src[30:23] = 8'(124 + int'(r[15:8]) % 70);
        else      src[62:52] = 11'(1020 + int'(r[15:8]) % 70);
      end
      issue_conv(r[1:0], r[3:2], src);
      collect_result();
    end

    for (int i = 0; i < 4; i++) issue_conv(2'(i), 2'(3 - i), DIR_VALS[4 * i + 2]);
    write_reg(`FCVT_ADDR_ISSUE, 32'd1, err);
    check_value("pslverr on issue with queue full", 64'(err), 64'd1);
    polls = 0;
    st    = '0;
    while (st[2:0] != 3'd4 && polls < 20) begin
      read_reg(`FCVT_ADDR_STATUS, st, err);
      polls++;
    end
    check_value("queue count when full", 64'(st[2:0]), 64'd4);
    repeat (4) collect_result();
    read_reg(`FCVT_ADDR_STATUS, st, err);
    check_value("STATUS after drain", 64'(st), 64'd0);

    wait (n_checked == n_issued);
    if (err_cnt == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("FAIL: see errors above");
      $fatal(1, "%0d checks failed", err_cnt);
    end
  end

endmodule
